// File: common/alloc_if.sv
`timescale 1ns/1ps

// allocation port between the free list and the rename map
interface alloc_if
	import rename_pkg::*;
();

	// taker pops the head this cycle
	logic pop;
	// current head of the free list
	phys_reg_t head_preg;
	// no free register left
	logic empty;
	// number of free registers
	// the top level reports this one directly
	fl_count_t count;

	// free list side
	modport provider (
		input pop,
		output head_preg,
		output empty,
		output count
	);

	// rename map side
	modport taker (
		output pop,
		input head_preg,
		input empty
	);

endinterface

// File: common/rename_config.svh
`ifndef RENAME_CONFIG_SVH
`define RENAME_CONFIG_SVH

// architectural registers visible to software
// after reset arch reg i maps to phys reg i
`define NUM_ARCH_REG 8

// physical registers, also the free list capacity
`define NUM_PHYS_REG 16

// retire queue entries
`define RQ_DEPTH 8

// derived widths
`define ARCH_REG_W ($clog2(`NUM_ARCH_REG))
`define PHYS_REG_W ($clog2(`NUM_PHYS_REG))
// count must reach NUM_PHYS_REG itself
`define FL_COUNT_W ($clog2(`NUM_PHYS_REG + 1))
`define RQ_PTR_W ($clog2(`RQ_DEPTH))
`define RQ_COUNT_W ($clog2(`RQ_DEPTH + 1))

`endif

// File: common/rename_pkg.sv
`include "rename_config.svh"

package rename_pkg;

	// architectural register number
	typedef logic [`ARCH_REG_W-1:0] arch_reg_t;

	// physical register number
	typedef logic [`PHYS_REG_W-1:0] phys_reg_t;

	// number of free physical registers, 0 up to NUM_PHYS_REG
	typedef logic [`FL_COUNT_W-1:0] fl_count_t;

	// one renamed instruction waiting to retire
	typedef struct packed {
		// destination as the program named it
		arch_reg_t dest_arch;
		// register given to the destination at rename
		phys_reg_t new_preg;
		// register it replaced, freed when this entry retires
		phys_reg_t old_preg;
	} rq_entry_t;

endpackage

// File: common/rq_push_if.sv
`timescale 1ns/1ps

// new renamed entry going into the retire queue
interface rq_push_if
	import rename_pkg::*;
();

	// write strobe, only while full is low
	logic push;
	logic full;
	rq_entry_t entry;

	// rename map side
	modport writer (
		output push,
		output entry,
		input full
	);

	// retire queue side
	modport reader (
		input push,
		input entry,
		output full
	);

endinterface

// File: design/free_list.sv
`timescale 1ns/1ps
`include "rename_config.svh"

// shifting FIFO of free physical register numbers
// head is always slot 0, tail counts the valid slots
module free_list
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	alloc_if.provider alloc,
	input logic release_en,
	input phys_reg_t release_preg
);

	phys_reg_t fl_mem [`NUM_PHYS_REG];
	phys_reg_t next_mem [`NUM_PHYS_REG];

	// number of valid entries, also the next write slot
	fl_count_t tail;
	fl_count_t next_tail;

	logic do_pop;
	logic do_push;

	assign alloc.head_preg = fl_mem[0];
	assign alloc.empty = (tail == '0);
	assign alloc.count = tail;

	// pop on empty is ignored
	assign do_pop = alloc.pop & (tail != '0);

	// a release at full capacity is dropped
	// unless a pop makes room in the same cycle
	assign do_push = release_en & (do_pop | (tail != fl_count_t'(`NUM_PHYS_REG)));

	always_comb begin
		next_mem = fl_mem;
		next_tail = tail;

		if (do_pop) begin
			// everything moves one slot toward the head
			for (int i = 0; i < `NUM_PHYS_REG - 1; i++) begin
				next_mem[i] = fl_mem[i + 1];
			end
			next_mem[`NUM_PHYS_REG - 1] = '0;
			next_tail = tail - 1'b1;
		end

		if (do_push) begin
			// with a pop this lands at old tail - 1, behind every older free reg
			next_mem[next_tail[`PHYS_REG_W-1:0]] = release_preg;
			next_tail = next_tail + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// phys regs below NUM_ARCH_REG hold the reset mapping
			// the rest start out free in ascending order
			for (int i = 0; i < `NUM_PHYS_REG; i++) begin
				if (i < `NUM_PHYS_REG - `NUM_ARCH_REG) begin
					fl_mem[i] <= phys_reg_t'(`NUM_ARCH_REG + i);
				end else begin
					fl_mem[i] <= '0;
				end
			end
			tail <= fl_count_t'(`NUM_PHYS_REG - `NUM_ARCH_REG);
		end else begin
			fl_mem <= next_mem;
			tail <= next_tail;
		end
	end

endmodule

// File: design/rename_core.sv
`timescale 1ns/1ps
`include "rename_config.svh"

// register rename core
// map stage, free list and retire queue wired together
module rename_core (
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input logic [`ARCH_REG_W-1:0] dispatch_dest,
	input logic [`ARCH_REG_W-1:0] dispatch_src,
	input logic retire_en,
	output logic dispatch_stall,
	output logic [`PHYS_REG_W-1:0] dispatch_preg,
	output logic [`PHYS_REG_W-1:0] src_preg,
	output logic [`FL_COUNT_W-1:0] free_count,
	output logic retire_valid,
	output logic [`ARCH_REG_W-1:0] retire_arch,
	output logic [`PHYS_REG_W-1:0] retire_preg
);

	// freed register path from retire back to the free list
	logic release_en;
	logic [`PHYS_REG_W-1:0] release_preg;

	alloc_if alloc ();
	rq_push_if rq ();

	assign free_count = alloc.count;

	rename_map u_rename_map (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_dest(dispatch_dest),
		.dispatch_src(dispatch_src),
		.dispatch_stall(dispatch_stall),
		.dispatch_preg(dispatch_preg),
		.src_preg(src_preg),
		.alloc(alloc.taker),
		.rq(rq.writer)
	);

	free_list u_free_list (
		.clock(clock),
		.reset(reset),
		.alloc(alloc.provider),
		.release_en(release_en),
		.release_preg(release_preg)
	);

	retire_queue u_retire_queue (
		.clock(clock),
		.reset(reset),
		.rq(rq.reader),
		.retire_en(retire_en),
		.retire_valid(retire_valid),
		.retire_arch(retire_arch),
		.retire_preg(retire_preg),
		.release_en(release_en),
		.release_preg(release_preg)
	);

endmodule

// File: design/rename_map.sv
`timescale 1ns/1ps
`include "rename_config.svh"

// map table from architectural to physical registers
// accepts at most one dispatch per cycle
module rename_map
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic dispatch_valid,
	input arch_reg_t dispatch_dest,
	input arch_reg_t dispatch_src,
	output logic dispatch_stall,
	output phys_reg_t dispatch_preg,
	output phys_reg_t src_preg,
	alloc_if.taker alloc,
	rq_push_if.writer rq
);

	// current mapping of each architectural register
	phys_reg_t map_table [`NUM_ARCH_REG];

	logic accept;

	// stall when there is no free register or no room to track the instruction
	assign dispatch_stall = alloc.empty | rq.full;
	assign accept = dispatch_valid & ~dispatch_stall;

	// the head of the free list is the register this dispatch would get
	assign dispatch_preg = alloc.head_preg;

	// source lookup sees the table before this cycle's update
	// so an instruction reading its own destination gets the old mapping
	assign src_preg = map_table[dispatch_src];

	// pop and push move together on an accepted dispatch
	assign alloc.pop = accept;
	assign rq.push = accept;

	// entry remembers what the destination used to map to
	always_comb begin
		rq.entry.dest_arch = dispatch_dest;
		rq.entry.new_preg = alloc.head_preg;
		rq.entry.old_preg = map_table[dispatch_dest];
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			// identity mapping, arch reg i lives in phys reg i
			for (int i = 0; i < `NUM_ARCH_REG; i++) begin
				map_table[i] <= phys_reg_t'(i);
			end
		end else if (accept) begin
			map_table[dispatch_dest] <= alloc.head_preg;
		end
	end

endmodule

// File: design/retire_queue.sv
`timescale 1ns/1ps
`include "rename_config.svh"

// in-order queue of renamed instructions
// retiring the oldest one gives its replaced register back to the free list
module retire_queue
	import rename_pkg::*;
(
	input logic clock,
	input logic reset,
	rq_push_if.reader rq,
	input logic retire_en,
	output logic retire_valid,
	output arch_reg_t retire_arch,
	output phys_reg_t retire_preg,
	output logic release_en,
	output phys_reg_t release_preg
);

	rq_entry_t rq_mem [`RQ_DEPTH];

	// oldest entry
	logic [`RQ_PTR_W-1:0] head;
	// next free slot
	logic [`RQ_PTR_W-1:0] tail;
	logic [`RQ_COUNT_W-1:0] occupancy;

	logic do_push;
	logic do_pop;

	assign rq.full = (occupancy == `RQ_COUNT_W'(`RQ_DEPTH));
	assign retire_valid = (occupancy != '0);

	assign do_push = rq.push & ~rq.full;
	// retire on an empty queue does nothing
	assign do_pop = retire_en & retire_valid;

	// head shown before it is popped
	// new_preg is now the committed home of retire_arch
	assign retire_arch = rq_mem[head].dest_arch;
	assign retire_preg = rq_mem[head].new_preg;

	// the replaced register is no longer reachable once this retires
	assign release_en = do_pop;
	assign release_preg = rq_mem[head].old_preg;

	always_ff @(posedge clock) begin
		if (do_push) begin
			rq_mem[tail] <= rq.entry;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			head <= '0;
			tail <= '0;
			occupancy <= '0;
		end else begin
			// depth is a power of two so the pointers wrap on their own
			if (do_push) begin
				tail <= tail + 1'b1;
			end
			if (do_pop) begin
				head <= head + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: occupancy <= occupancy + 1'b1;
				2'b01: occupancy <= occupancy - 1'b1;
				default: occupancy <= occupancy;
			endcase
		end
	end

endmodule

// File: filelist.f
+incdir+common
common/rename_pkg.sv
common/alloc_if.sv
common/rq_push_if.sv
design/rename_map.sv
design/free_list.sv
design/retire_queue.sv
design/rename_core.sv
verif/tb_rename_core.sv

// File: run_sim.sh
#!/bin/sh
# build and run the rename core testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_rename_core

output=$(./obj_dir/Vtb_rename_core 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'STATUS: PASS'; then
	exit 0
fi
exit 1

// File: verif/tb_rename_core.sv
`timescale 1ns/1ps
`include "rename_config.svh"

// testbench for the rename core
// a queue based model shadows the free list, map table and retire queue
module tb_rename_core
	import rename_pkg::*;
();

	logic clock;
	logic reset;
	logic dispatch_valid;
	arch_reg_t dispatch_dest;
	arch_reg_t dispatch_src;
	logic retire_en;
	logic dispatch_stall;
	phys_reg_t dispatch_preg;
	phys_reg_t src_preg;
	fl_count_t free_count;
	logic retire_valid;
	arch_reg_t retire_arch;
	phys_reg_t retire_preg;

	// model state
	phys_reg_t m_free[$];
	phys_reg_t m_map [`NUM_ARCH_REG];
	rq_entry_t m_rq[$];

	logic [7:0] lfsr_state;

	rename_core u_rename_core (
		.clock(clock),
		.reset(reset),
		.dispatch_valid(dispatch_valid),
		.dispatch_dest(dispatch_dest),
		.dispatch_src(dispatch_src),
		.retire_en(retire_en),
		.dispatch_stall(dispatch_stall),
		.dispatch_preg(dispatch_preg),
		.src_preg(src_preg),
		.free_count(free_count),
		.retire_valid(retire_valid),
		.retire_arch(retire_arch),
		.retire_preg(retire_preg)
	);

	always #50 clock = ~clock;

	// galois lfsr, one step per bit taken
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[6:0], lfsr_state[0]};
			if (lfsr_state[0]) begin
				lfsr_state = (lfsr_state >> 1) ^ 8'hB8;
			end else begin
				lfsr_state = lfsr_state >> 1;
			end
		end
		return bits;
	endfunction

	// identity map, phys regs 8 to 15 free in order
	function automatic void model_reset();
		m_free.delete();
		m_rq.delete();
		for (int i = 0; i < `NUM_ARCH_REG; i++) begin
			m_map[i] = phys_reg_t'(i);
		end
		for (int i = `NUM_ARCH_REG; i < `NUM_PHYS_REG; i++) begin
			m_free.push_back(phys_reg_t'(i));
		end
	endfunction

	// reference step for one rising edge
	function automatic void model_step();
		logic accept;
		logic retire;
		rq_entry_t new_e;
		rq_entry_t done_e;
		accept = dispatch_valid && (m_free.size() != 0) && (m_rq.size() != `RQ_DEPTH);
		retire = retire_en && (m_rq.size() != 0);
		if (retire) begin
			done_e = m_rq.pop_front();
		end
		if (accept) begin
			new_e.dest_arch = dispatch_dest;
			new_e.new_preg = m_free.pop_front();
			new_e.old_preg = m_map[dispatch_dest];
			m_map[dispatch_dest] = new_e.new_preg;
			m_rq.push_back(new_e);
		end
		// released reg goes behind every reg already free
		if (retire) begin
			m_free.push_back(done_e.old_preg);
		end
	endfunction

	always @(posedge clock) begin
		if (reset) begin
			model_reset();
		end else begin
			model_step();
		end
	end

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("STATUS: FAIL");
		$fatal(1, "output mismatch");
	endtask

	task automatic give_up(input string what);
		$display("timeout while waiting: %s", what);
		$display("STATUS: FAIL");
		$fatal(1, "wait timed out");
	endtask

	task automatic expect_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else report_mismatch(name, got, exp);
	endtask

	// every output against the model
	task automatic check_outputs();
		logic exp_stall;
		exp_stall = (m_free.size() == 0) || (m_rq.size() == `RQ_DEPTH);
		expect_value("dispatch_stall", 32'(dispatch_stall), 32'(exp_stall));
		expect_value("free_count", 32'(free_count), 32'(m_free.size()));
		expect_value("src_preg", 32'(src_preg), 32'(m_map[dispatch_src]));
		expect_value("retire_valid", 32'(retire_valid), 32'(m_rq.size() != 0));
		// head values only mean something when there is a head
		if (m_free.size() != 0) begin
			expect_value("dispatch_preg", 32'(dispatch_preg), 32'(m_free[0]));
		end
		if (m_rq.size() != 0) begin
			expect_value("retire_arch", 32'(retire_arch), 32'(m_rq[0].dest_arch));
			expect_value("retire_preg", 32'(retire_preg), 32'(m_rq[0].new_preg));
		end
	endtask

	// compare in the low phase, well after inputs move
	initial begin
		forever begin
			@(negedge clock);
			#10;
			if (!reset) begin
				check_outputs();
			end
		end
	end

	task automatic drive(input logic v, input arch_reg_t d, input arch_reg_t s,
			input logic r);
		@(negedge clock);
		dispatch_valid = v;
		dispatch_dest = d;
		dispatch_src = s;
		retire_en = r;
	endtask

	initial begin
		int n;
		logic v;
		logic r;
		arch_reg_t d;
		arch_reg_t s;
		clock = 1'b0;
		reset = 1'b1;
		dispatch_valid = 1'b0;
		dispatch_dest = '0;
		dispatch_src = '0;
		retire_en = 1'b0;
		lfsr_state = 8'd59;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		#10;
		expect_value("free_count", 32'(free_count), 32'(`NUM_PHYS_REG - `NUM_ARCH_REG));
		expect_value("retire_valid", 32'(retire_valid), 32'h0);
		expect_value("dispatch_stall", 32'(dispatch_stall), 32'h0);

		// fill until stalled, sources chase the previous destination
		n = 0;
		while (!dispatch_stall) begin
			drive(1'b1, arch_reg_t'(n), arch_reg_t'(n + 7), 1'b0);
			#10;
			if (!dispatch_stall) begin
				expect_value("dispatch_preg", 32'(dispatch_preg), 32'(`NUM_ARCH_REG + n));
			end
			n++;
			if (n > 2 * `RQ_DEPTH) begin
				give_up("dispatch_stall never rose");
			end
		end
		// stalled dispatches change nothing
		repeat (3) drive(1'b1, 3'd2, 3'd2, 1'b0);
		#10;
		expect_value("free_count", 32'(free_count), 32'h0);

		// one retire clears the stall
		drive(1'b0, '0, '0, 1'b1);
		drive(1'b0, '0, 3'd1, 1'b0);
		#10;
		expect_value("dispatch_stall", 32'(dispatch_stall), 32'h0);

		// second retire so the free list holds more than one reg
		drive(1'b0, '0, '0, 1'b1);

		// dispatch and retire together keep the count
		repeat (3) drive(1'b1, 3'd5, 3'd0, 1'b1);
		drive(1'b0, '0, '0, 1'b0);
		#10;
		expect_value("free_count", 32'(free_count), 32'h2);

		n = 0;
		while (retire_valid) begin
			drive(1'b0, '0, '0, 1'b1);
			#10;
			n++;
			if (n > 2 * `RQ_DEPTH) begin
				give_up("retire queue did not drain");
			end
		end

		// random mix, dispatch about three cycles in four
		for (int i = 0; i < 600; i++) begin
			v = (take_bits(2) != 8'h0);
			r = (take_bits(1) != 8'h0);
			d = arch_reg_t'(take_bits(3));
			s = arch_reg_t'(take_bits(3));
			drive(v, d, s, r);
		end
		drive(1'b0, '0, '0, 1'b0);
		@(negedge clock);
		#20;

		$display("STATUS: PASS");
		$finish;
	end

endmodule
